// ==== project.f ====
+incdir+include
rtl/afifo_pkg.sv
rtl/afifo_ptr_sync.sv
rtl/afifo_wr_ctrl.sv
rtl/afifo_rd_ctrl.sv
rtl/afifo_dpram.sv
rtl/afifo_top.sv
verification/afifo_tb_clk.sv
verification/afifo_tb.sv

// ==== Bender.yml ====
package:
  name: afifo

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/afifo_pkg.sv
      - rtl/afifo_ptr_sync.sv
      - rtl/afifo_wr_ctrl.sv
      - rtl/afifo_rd_ctrl.sv
      - rtl/afifo_dpram.sv
      - rtl/afifo_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/afifo_tb_clk.sv
      - verification/afifo_tb.sv

// ==== verification/afifo_tb.sv ====
`include "afifo_macros.svh"

module afifo_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RD_PERIOD_NS  = 8;
   localparam int WR_PERIOD_NS  = 12;
   localparam int RST_CYCLES    = 8;      // rd_clk cycles
   localparam int SETTLE_CYCLES = 8;      // idle cycles of each clock
   localparam int FILL_CYCLES   = 24;     // longer than the depth
   localparam int MIX_WR_CYCLES = 200;
   localparam int MIX_RD_CYCLES = MIX_WR_CYCLES * WR_PERIOD_NS / RD_PERIOD_NS;
   localparam int N_CFG         = 4;
   localparam int DEPTH         = `AFIFO_DEPTH;
   localparam int PIPE          = `AFIFO_RAM_PIPE_STAGE;
   localparam logic [31:0] SEED = 32'h34b5_eea1;
   localparam int WATCHDOG_NS   = (RST_CYCLES + 2 * FILL_CYCLES + N_CFG * MIX_WR_CYCLES
                                   + (N_CFG + 2) * 2 * (SETTLE_CYCLES + 1)) * WR_PERIOD_NS
                                  + 1000;

   logic wr_clk, wr_rst_n, wr_en, full, prog_full, ovf_int;
   logic rd_clk, rd_rst_n, rd_en, rd_data_val, empty, prog_empty, udf_int;
   afifo_pkg::data_t wr_data, rd_data;
   afifo_pkg::ptr_t  prog_full_assert_cfg, prog_full_negate_cfg, data_count;

   // prog_full configurations and traffic mix per mixed phase
   int cfg_assert [N_CFG] = '{12, 16, 4, 10};
   int cfg_negate [N_CFG] = '{8, 16, 2, 6};
   int wr_pct     [N_CFG] = '{70, 90, 50, 80};
   int rd_pct     [N_CFG] = '{50, 40, 70, 30};

   afifo_pkg::data_t model_q [$];    // words inside the fifo
   afifo_pkg::data_t pend_data [$];  // read out, still in the pipeline
   int               pend_due [$];   // rd_cycle at which each arrives
   int               rd_cycle;
   logic             ovf_exp, udf_exp, val_exp;
   logic [31:0]      wr_rng, rd_rng; // one stream per clock domain
   int               error_cnt = 0;
   int               check_cnt = 0;

   afifo_tb_clk #(.PERIOD_NS(WR_PERIOD_NS)) i_wr_clk (.clk(wr_clk));
   afifo_tb_clk #(.PERIOD_NS(RD_PERIOD_NS)) i_rd_clk (.clk(rd_clk));

   afifo_top i_dut (
      .wr_clk (wr_clk), .wr_rst_n (wr_rst_n), .wr_en (wr_en), .wr_data (wr_data),
      .prog_full_assert_cfg (prog_full_assert_cfg),
      .prog_full_negate_cfg (prog_full_negate_cfg),
      .full (full), .prog_full (prog_full), .ovf_int (ovf_int),
      .rd_clk (rd_clk), .rd_rst_n (rd_rst_n), .rd_en (rd_en), .rd_data (rd_data),
      .rd_data_val (rd_data_val), .empty (empty), .prog_empty (prog_empty),
      .udf_int (udf_int), .data_count (data_count)
   );

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
   endfunction

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      check_cnt++;
      if (actual !== expected)
      begin
         error_cnt++;
         $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns",
                  name, actual, expected, $time);
      end
   endtask

   task automatic report_failure(input string msg);
      error_cnt++;
      $display("failure at %0t ns: %s", $time, msg);
   endtask

   task automatic report_and_finish();
      $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
      if (error_cnt == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   endtask

   task automatic check_reset_values();
      check_value("full", full, 1'b0);
      check_value("prog_full", prog_full, 1'b0);
      check_value("ovf_int", ovf_int, 1'b0);
      check_value("udf_int", udf_int, 1'b0);
      check_value("rd_data_val", rd_data_val, 1'b0);
      check_value("empty", empty, 1'b1);
      check_value("prog_empty", prog_empty, 1'b1);
   endtask

   // pct is the chance of wr_en per cycle, in percent
   task automatic write_burst(input int n_cycles, input int pct);
      for (int i = 0; i < n_cycles; i++)
      begin
         @(negedge wr_clk);
         wr_rng  = lcg_step(wr_rng);
         wr_en   = ((wr_rng >> 8) % 100) < pct;
         wr_rng  = lcg_step(wr_rng);
         wr_data = afifo_pkg::data_t'(wr_rng);
      end
      @(negedge wr_clk);
      wr_en = 1'b0;
   endtask

   task automatic read_burst(input int n_cycles, input int pct);
      for (int i = 0; i < n_cycles; i++)
      begin
         @(negedge rd_clk);
         rd_rng = lcg_step(rd_rng);
         rd_en  = ((rd_rng >> 8) % 100) < pct;
      end
      @(negedge rd_clk);
      rd_en = 1'b0;
   endtask

   // both pointers synced, so the flags must be exact
   task automatic check_settled();
      int cnt;
      repeat (SETTLE_CYCLES) @(negedge wr_clk);
      repeat (SETTLE_CYCLES) @(negedge rd_clk);
      cnt = model_q.size();
      check_value("data_count", data_count, cnt);
      check_value("empty", empty, cnt == 0);
      if (cnt <= `AFIFO_PROG_EMPTY_ASSERT)
         check_value("prog_empty", prog_empty, 1'b1);
      else if (cnt > `AFIFO_PROG_EMPTY_NEGATE)
         check_value("prog_empty", prog_empty, 1'b0);
      @(negedge wr_clk);
      check_value("full", full, cnt == DEPTH);
      if (cnt >= prog_full_assert_cfg)
         check_value("prog_full", prog_full, 1'b1);
      else if (cnt < prog_full_negate_cfg)
         check_value("prog_full", prog_full, 1'b0);   // inside the band either is fine
   endtask

   // ------------------------------------------------------------------------
   // monitors, sampled at the rising edge before the DUT updates
   // ------------------------------------------------------------------------
   always @(posedge wr_clk)
   begin
      if (wr_rst_n)
      begin
         check_value("ovf_int", ovf_int, ovf_exp);
         if (!full && model_q.size() >= DEPTH)
            report_failure("full is low while the model holds a full fifo");
         ovf_exp = wr_en && full;                 // seen one cycle later
         if (wr_en && !full)
            model_q.push_back(wr_data);
      end
      else
         ovf_exp = 1'b0;
   end

   always @(posedge rd_clk)
   begin
      if (rd_rst_n)
      begin
         rd_cycle++;
         check_value("udf_int", udf_int, udf_exp);
         if (!empty && model_q.size() == 0)
            report_failure("empty is low while the model holds no word");
         val_exp = (pend_due.size() > 0) && (pend_due[0] == rd_cycle);
         check_value("rd_data_val", rd_data_val, val_exp);
         if (val_exp)
         begin
            check_value("rd_data", rd_data, pend_data[0]);
            pend_data.delete(0);
            pend_due.delete(0);
         end
         udf_exp = rd_en && empty;
         if (rd_en && !empty && model_q.size() > 0)
         begin
            pend_data.push_back(model_q.pop_front());
            pend_due.push_back(rd_cycle + PIPE);   // fixed read latency
         end
      end
      else
      begin
         udf_exp  = 1'b0;
         rd_cycle = 0;
      end
   end

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial
   begin
      wr_rng               = SEED;
      rd_rng               = ~SEED;
      wr_en                = 1'b0;
      wr_data              = '0;
      rd_en                = 1'b0;
      prog_full_assert_cfg = afifo_pkg::ptr_t'(cfg_assert[0]);
      prog_full_negate_cfg = afifo_pkg::ptr_t'(cfg_negate[0]);
      wr_rst_n             = 1'b0;
      rd_rst_n             = 1'b0;
      repeat (RST_CYCLES / 2) @(negedge rd_clk);
      check_reset_values();
      repeat (RST_CYCLES / 2) @(negedge rd_clk);
      wr_rst_n = 1'b1;
      rd_rst_n = 1'b1;

      write_burst(FILL_CYCLES, 100);             // fill, then overflow
      check_settled();
      read_burst(FILL_CYCLES, 100);              // drain, then underflow
      check_settled();

      for (int k = 0; k < N_CFG; k++)
      begin
         @(negedge wr_clk);
         prog_full_assert_cfg = afifo_pkg::ptr_t'(cfg_assert[k]);
         prog_full_negate_cfg = afifo_pkg::ptr_t'(cfg_negate[k]);
         fork
            write_burst(MIX_WR_CYCLES, wr_pct[k]);
            read_burst(MIX_RD_CYCLES, rd_pct[k]);
         join
         check_settled();
      end
      report_and_finish();
   end

   // watchdog
   initial
   begin
      #(WATCHDOG_NS);
      report_failure("watchdog expired before the test sequence completed");
      report_and_finish();
   end

endmodule

// ==== verification/afifo_tb_clk.sv ====
module afifo_tb_clk
#(
   parameter int PERIOD_NS = 8     // full clock period
)
(
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   // free running, low for the first half period
   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

endmodule

// ==== rtl/afifo_top.sv ====
module afifo_top
(
   // write domain
   input  logic             wr_clk,
   input  logic             wr_rst_n,
   input  logic             wr_en,
   input  afifo_pkg::data_t wr_data,
   input  afifo_pkg::ptr_t  prog_full_assert_cfg,
   input  afifo_pkg::ptr_t  prog_full_negate_cfg,
   output logic             full,
   output logic             prog_full,
   output logic             ovf_int,
   // read domain
   input  logic             rd_clk,
   input  logic             rd_rst_n,
   input  logic             rd_en,
   output afifo_pkg::data_t rd_data,
   output logic             rd_data_val,
   output logic             empty,
   output logic             prog_empty,
   output logic             udf_int,
   output afifo_pkg::ptr_t  data_count
);

   // ------------------------------------------------------------------------
   // crossing and storage wires
   // ------------------------------------------------------------------------
   logic             wr_accept;
   afifo_pkg::addr_t wr_addr;
   afifo_pkg::ptr_t  wr_gray;         // launched on wr_clk
   afifo_pkg::ptr_t  wr_gray_sync;    // landed on rd_clk
   logic             rd_accept;
   afifo_pkg::addr_t rd_addr;
   afifo_pkg::ptr_t  rd_gray;         // launched on rd_clk
   afifo_pkg::ptr_t  rd_gray_sync;    // landed on wr_clk

   afifo_wr_ctrl i_wr_ctrl (
      .wr_clk               (wr_clk),
      .wr_rst_n             (wr_rst_n),
      .wr_en                (wr_en),
      .prog_full_assert_cfg (prog_full_assert_cfg),
      .prog_full_negate_cfg (prog_full_negate_cfg),
      .rd_gray_sync         (rd_gray_sync),
      .wr_accept            (wr_accept),
      .wr_addr              (wr_addr),
      .wr_gray              (wr_gray),
      .full                 (full),
      .prog_full            (prog_full),
      .ovf_int              (ovf_int)
   );

   afifo_rd_ctrl i_rd_ctrl (
      .rd_clk       (rd_clk),
      .rd_rst_n     (rd_rst_n),
      .rd_en        (rd_en),
      .wr_gray_sync (wr_gray_sync),
      .rd_accept    (rd_accept),
      .rd_addr      (rd_addr),
      .rd_gray      (rd_gray),
      .empty        (empty),
      .prog_empty   (prog_empty),
      .udf_int      (udf_int),
      .data_count   (data_count)
   );

   // write pointer into rd_clk
   afifo_ptr_sync i_wr2rd_sync (
      .clk      (rd_clk),
      .rst_n    (rd_rst_n),
      .gray_in  (wr_gray),
      .gray_out (wr_gray_sync)
   );

   // read pointer into wr_clk
   afifo_ptr_sync i_rd2wr_sync (
      .clk      (wr_clk),
      .rst_n    (wr_rst_n),
      .gray_in  (rd_gray),
      .gray_out (rd_gray_sync)
   );

   afifo_dpram i_dpram (
      .wr_clk      (wr_clk),
      .wr_accept   (wr_accept),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .rd_clk      (rd_clk),
      .rd_rst_n    (rd_rst_n),
      .rd_accept   (rd_accept),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .rd_data_val (rd_data_val)
   );

endmodule

// ==== rtl/afifo_dpram.sv ====
`include "afifo_macros.svh"

module afifo_dpram
(
   input  logic             wr_clk,
   input  logic             wr_accept,
   input  afifo_pkg::addr_t wr_addr,
   input  afifo_pkg::data_t wr_data,
   input  logic             rd_clk,
   input  logic             rd_rst_n,     // valid line only
   input  logic             rd_accept,
   input  afifo_pkg::addr_t rd_addr,
   output afifo_pkg::data_t rd_data,
   output logic             rd_data_val
);

   localparam int PIPE = `AFIFO_RAM_PIPE_STAGE;

   afifo_pkg::data_t mem [`AFIFO_DEPTH];     // flop storage
   afifo_pkg::data_t pipe_q [PIPE];          // read data stages
   logic [PIPE-1:0]  val_q;                  // valid delay line

   // ------------------------------------------------------------------------
   // write port, wr_clk
   // ------------------------------------------------------------------------
   always_ff @(posedge wr_clk)
   begin
      if (wr_accept)
         mem[wr_addr] <= wr_data;
   end

   // ------------------------------------------------------------------------
   // read port, rd_clk, first stage loads only on an accepted read
   // ------------------------------------------------------------------------
   always_ff @(posedge rd_clk)
   begin
      if (rd_accept)
         pipe_q[0] <= mem[rd_addr];
      for (int i = 1; i < PIPE; i++)
         pipe_q[i] <= pipe_q[i-1];            // free-running shift
   end

   always_ff @(posedge rd_clk or negedge rd_rst_n)
   begin
      if (!rd_rst_n)
         val_q <= '0;
      else
      begin
         val_q[0] <= rd_accept;
         for (int i = 1; i < PIPE; i++)
            val_q[i] <= val_q[i-1];
      end
   end

   assign rd_data     = pipe_q[PIPE-1];
   assign rd_data_val = val_q[PIPE-1];

   // every accepted read returns a stored word exactly PIPE edges later
   a_val_latency : assert property (
      @(posedge rd_clk) disable iff (!rd_rst_n)
      rd_accept |-> ##PIPE (rd_data_val && !$isunknown(rd_data)));

endmodule

// ==== rtl/afifo_rd_ctrl.sv ====
`include "afifo_macros.svh"

module afifo_rd_ctrl
(
   input  logic             rd_clk,
   input  logic             rd_rst_n,
   input  logic             rd_en,          // one word per cycle
   input  afifo_pkg::ptr_t  wr_gray_sync,   // write pointer, already in rd_clk
   output logic             rd_accept,      // storage read strobe
   output afifo_pkg::addr_t rd_addr,
   output afifo_pkg::ptr_t  rd_gray,        // to the write side synchronizer
   output logic             empty,
   output logic             prog_empty,
   output logic             udf_int,        // refused read, one cycle
   output afifo_pkg::ptr_t  data_count      // words held as seen from here
);

   afifo_pkg::ptr_t rd_ptr;       // binary, msb is the wrap bit
   afifo_pkg::ptr_t rd_ptr_nxt;
   afifo_pkg::ptr_t wr_bin;       // synced write pointer in binary

   // ------------------------------------------------------------------------
   // pointer arithmetic
   // ------------------------------------------------------------------------
   assign rd_accept  = rd_en && !empty;                       // drop while empty
   assign rd_ptr_nxt = rd_ptr + afifo_pkg::ptr_t'(rd_accept);
   assign rd_addr    = rd_ptr[`AFIFO_ADDR_WIDTH-1:0];

   assign wr_bin     = afifo_pkg::gray2bin(wr_gray_sync);
   assign data_count = wr_bin - rd_ptr;      // lagging write ptr, never too high

   always_ff @(posedge rd_clk or negedge rd_rst_n)
   begin
      if (!rd_rst_n)
      begin
         rd_ptr  <= '0;
         rd_gray <= '0;
         empty   <= 1'b1;
         udf_int <= 1'b0;
      end
      else
      begin
         rd_ptr  <= rd_ptr_nxt;
         rd_gray <= afifo_pkg::bin2gray(rd_ptr_nxt);
         // early rise when the last stored word leaves now
         empty   <= (data_count == '0) || ((data_count == 1) && rd_accept);
         udf_int <= rd_en && empty;                     // refused read
      end
   end

   // ------------------------------------------------------------------------
   // prog_empty with hysteresis, fixed thresholds
   // ------------------------------------------------------------------------
   always_ff @(posedge rd_clk or negedge rd_rst_n)
   begin
      if (!rd_rst_n)
         prog_empty <= 1'b1;                                  // starts empty
      else if (data_count <= `AFIFO_PROG_EMPTY_ASSERT)
         prog_empty <= 1'b1;
      else if (data_count > `AFIFO_PROG_EMPTY_NEGATE)
         prog_empty <= 1'b0;
   end

   // count stays in range only if the write side honours its full flag
   a_count_in_range : assert property (
      @(posedge rd_clk) disable iff (!rd_rst_n)
      data_count <= `AFIFO_DEPTH);

endmodule

// ==== rtl/afifo_wr_ctrl.sv ====
`include "afifo_macros.svh"

module afifo_wr_ctrl
(
   input  logic             wr_clk,
   input  logic             wr_rst_n,
   input  logic             wr_en,                  // one word per cycle
   input  afifo_pkg::ptr_t  prog_full_assert_cfg,   // fill at or above sets prog_full
   input  afifo_pkg::ptr_t  prog_full_negate_cfg,   // fill below clears prog_full
   input  afifo_pkg::ptr_t  rd_gray_sync,           // read pointer, already in wr_clk
   output logic             wr_accept,              // storage write strobe
   output afifo_pkg::addr_t wr_addr,
   output afifo_pkg::ptr_t  wr_gray,                // to the read side synchronizer
   output logic             full,
   output logic             prog_full,
   output logic             ovf_int                 // refused write, one cycle
);

   afifo_pkg::ptr_t wr_ptr;       // binary, msb is the wrap bit
   afifo_pkg::ptr_t wr_ptr_nxt;   // pointer after this edge
   afifo_pkg::ptr_t rd_bin;       // synced read pointer in binary
   afifo_pkg::ptr_t wr_fill;      // words held as seen from here
   afifo_pkg::ptr_t wr_free;      // words still free

   // ------------------------------------------------------------------------
   // pointer arithmetic
   // ------------------------------------------------------------------------
   assign wr_accept  = wr_en && !full;                        // drop while full
   assign wr_ptr_nxt = wr_ptr + afifo_pkg::ptr_t'(wr_accept);
   assign wr_addr    = wr_ptr[`AFIFO_ADDR_WIDTH-1:0];         // wrap bit dropped

   assign rd_bin  = afifo_pkg::gray2bin(rd_gray_sync);
   assign wr_fill = wr_ptr - rd_bin;                          // mod 2*depth
   assign wr_free = afifo_pkg::ptr_t'(`AFIFO_DEPTH) - wr_fill;

   // read pointer lags, so free space is never overstated
   always_ff @(posedge wr_clk or negedge wr_rst_n)
   begin
      if (!wr_rst_n)
      begin
         wr_ptr  <= '0;
         wr_gray <= '0;
         full    <= 1'b0;
         ovf_int <= 1'b0;
      end
      else
      begin
         wr_ptr  <= wr_ptr_nxt;
         wr_gray <= afifo_pkg::bin2gray(wr_ptr_nxt);   // published with the ptr
         // early rise when the last free word goes now
         full    <= (wr_free == '0) || ((wr_free == 1) && wr_accept);
         ovf_int <= wr_en && full;                      // refused write
      end
   end

   // ------------------------------------------------------------------------
   // prog_full with hysteresis, thresholds from the config inputs
   // ------------------------------------------------------------------------
   always_ff @(posedge wr_clk or negedge wr_rst_n)
   begin
      if (!wr_rst_n)
         prog_full <= 1'b0;
      else if (wr_fill >= prog_full_assert_cfg)
         prog_full <= 1'b1;
      else if (wr_fill < prog_full_negate_cfg)
         prog_full <= 1'b0;
      // between the two levels hold
   end

   // a full fifo must hold its write pointer, otherwise unread data is lost
   a_no_advance_when_full : assert property (
      @(posedge wr_clk) disable iff (!wr_rst_n)
      wr_accept |-> (wr_free != '0));

endmodule

// ==== rtl/afifo_ptr_sync.sv ====
module afifo_ptr_sync
(
   input  logic            clk,       // receiving domain clock
   input  logic            rst_n,     // receiving domain reset
   input  afifo_pkg::ptr_t gray_in,   // gray pointer, launched in other domain
   output afifo_pkg::ptr_t gray_out   // same pointer, safe to use here
);

   // first stage may go metastable, never read it directly
   afifo_pkg::ptr_t meta_q;

   // ------------------------------------------------------------------------
   // two-flop synchronizer
   // only one bit moves per source update, so a late sample is just old
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         meta_q   <= '0;
         gray_out <= '0;
      end
      else
      begin
         meta_q   <= gray_in;      // capture
         gray_out <= meta_q;       // settle
      end
   end

endmodule

// ==== rtl/afifo_pkg.sv ====
`include "afifo_macros.svh"

package afifo_pkg;

   typedef logic [`AFIFO_ADDR_WIDTH:0]   ptr_t;   // address plus wrap bit
   typedef logic [`AFIFO_ADDR_WIDTH-1:0] addr_t;  // storage index
   typedef logic [`AFIFO_DATA_WIDTH-1:0] data_t;  // one fifo word

   // adjacent codes differ in a single bit
   function automatic ptr_t bin2gray(input ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   // running xor from the msb down
   function automatic ptr_t gray2bin(input ptr_t gray);
      ptr_t bin;
      bin[`AFIFO_ADDR_WIDTH] = gray[`AFIFO_ADDR_WIDTH];
      for (int i = `AFIFO_ADDR_WIDTH - 1; i >= 0; i--)
         bin[i] = bin[i+1] ^ gray[i];
      return bin;
   endfunction

endpackage

// ==== include/afifo_macros.svh ====
`ifndef AFIFO_MACROS_SVH
`define AFIFO_MACROS_SVH

// ----------------------------------------------------------------------------
// fifo geometry
// ----------------------------------------------------------------------------
`define AFIFO_ADDR_WIDTH        4                        // storage address bits
`define AFIFO_DATA_WIDTH        32                       // word width
`define AFIFO_DEPTH             (1 << `AFIFO_ADDR_WIDTH) // words held

// read path
`define AFIFO_RAM_PIPE_STAGE    2   // rd_clk cycles from accept to valid, min 1

// ----------------------------------------------------------------------------
// prog_empty thresholds, compared against data_count
// ----------------------------------------------------------------------------
`define AFIFO_PROG_EMPTY_ASSERT 3   // at or below this prog_empty rises
`define AFIFO_PROG_EMPTY_NEGATE 5   // above this prog_empty falls

`endif
